// ==== verilog/fwd_pkg.sv ====
`default_nettype none

package fwd_pkg;

  // Datapath and register index widths
  localparam int XLEN_W = 32;
  localparam int REG_W  = 5;

  typedef logic [XLEN_W-1:0] xlen_t;
  typedef logic [REG_W-1:0]  reg_idx_t;

  // Supported opcodes, shifts use the low 5 bits of operand B
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_SLL,
    OP_SRL,
    OP_LW,
    OP_SW
  } op_e;

  ////////////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////////////

  // ID/EX, operands as read from the register file
  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    imm;
    logic     alusrc;
    logic     regwrite;
  } id_ex_t;

  // EX/MEM, ALU result doubles as memory address
  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    logic     regwrite;
    logic     memread;
    xlen_t    alures;
    xlen_t    store_data;
  } ex_mem_t;

  // MEM/WB, stdata is zero unless the slot holds a store
  typedef struct packed {
    reg_idx_t rd;
    logic     regwrite;
    logic     memread;
    xlen_t    alures;
    xlen_t    stdata;
  } mem_wb_t;

  // One write-back record, used for the WB/ID echo
  typedef struct packed {
    logic     regwrite;
    reg_idx_t rd;
    xlen_t    data;
  } wb_rec_t;

endpackage

`default_nettype wire

// ==== verilog/wb_bus_if.sv ====
`default_nettype none

interface wb_bus_if;
  import fwd_pkg::*;

  // Write performed at this edge, already qualified by the output transfer
  logic     regwrite;
  reg_idx_t rd;
  xlen_t    data;

  // Copy of the previous write, held while the pipeline is frozen
  wb_rec_t  echo;

  // Driven from the MEM/WB stage
  modport wb_src (output regwrite, rd, data, echo);

  // Register file write port
  modport wb_dst (input regwrite, rd, data);

  // Forwarding looks at the current write and at the echo
  modport fwd_view (input regwrite, rd, echo);

endinterface

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none

module regfile #(
  parameter int XLEN = 32
) (
  input  wire                clk,
  input  wire                arst_n,
  input  fwd_pkg::reg_idx_t  rd_idx_a,
  input  fwd_pkg::reg_idx_t  rd_idx_b,
  output fwd_pkg::xlen_t     rd_data_a,
  output fwd_pkg::xlen_t     rd_data_b,
  wb_bus_if.wb_dst           wb
);

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  // Write port, one edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.regwrite && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Combinational reads
  // x0 always returns zero
  assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== verilog/forwarding.sv ====
`default_nettype none

module forwarding #(
  parameter int XLEN = 32
) (
  input  wire                ex_mem_regwrite,
  input  wire                ex_mem_memread,
  input  fwd_pkg::reg_idx_t  ex_mem_rd,
  input  fwd_pkg::reg_idx_t  id_ex_rs1,
  input  fwd_pkg::reg_idx_t  id_ex_rs2,
  input  fwd_pkg::xlen_t     alures,
  input  fwd_pkg::xlen_t     memres,
  input  fwd_pkg::xlen_t     rs1,
  input  fwd_pkg::xlen_t     rs2,
  input  fwd_pkg::xlen_t     imm,
  input  wire                alusrc,
  wb_bus_if.fwd_view         wb,
  output fwd_pkg::xlen_t     fw_rs1,
  output fwd_pkg::xlen_t     fw_rs2,
  output fwd_pkg::xlen_t     rs2_mod
);
  import fwd_pkg::*;

  // Operand sources, youngest producer first
  typedef enum logic [1:0] {
    SEL_REG,
    SEL_EXM,
    SEL_MWB,
    SEL_ECHO
  } fw_sel_e;

  fw_sel_e sel_fw1;
  fw_sel_e sel_fw2;

  // Source select for one operand index
  function automatic fw_sel_e pick(input reg_idx_t idx);
    if (idx == '0)
      return SEL_REG;
    // A load in EX/MEM has no data yet
    else if (ex_mem_regwrite && !ex_mem_memread && (ex_mem_rd == idx))
      return SEL_EXM;
    else if (wb.regwrite && (wb.rd == idx))
      return SEL_MWB;
    // Written after this instruction read the register file
    else if (wb.echo.regwrite && (wb.echo.rd == idx))
      return SEL_ECHO;
    else
      return SEL_REG;
  endfunction

  // Operand mux
  function automatic logic [XLEN-1:0] fw_mux(input fw_sel_e sel,
                                             input logic [XLEN-1:0] regval);
    case (sel)
      SEL_EXM:  return alures;
      SEL_MWB:  return memres;
      SEL_ECHO: return wb.echo.data;
      default:  return regval;
    endcase
  endfunction

  assign sel_fw1 = pick(id_ex_rs1);
  assign sel_fw2 = pick(id_ex_rs2);

  assign fw_rs1  = fw_mux(sel_fw1, rs1);
  // Forwarded rs2 also carries store data
  assign rs2_mod = fw_mux(sel_fw2, rs2);

  // Immediate or register for ALU operand B
  assign fw_rs2  = alusrc ? imm : rs2_mod;

endmodule

`default_nettype wire

// ==== verilog/exec_alu.sv ====
`default_nettype none

module exec_alu #(
  parameter int XLEN = 32
) (
  input  fwd_pkg::op_e    op,
  input  fwd_pkg::xlen_t  a,
  input  fwd_pkg::xlen_t  b,
  output fwd_pkg::xlen_t  result
);
  import fwd_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt;

  // Shift amount from the low bits of B
  assign shamt = b[SHW-1:0];
  // Signed compare for SLT
  assign lt    = ($signed(a) < $signed(b));

  always_comb begin
    case (op)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      OP_SLT:  result = {{(XLEN-1){1'b0}}, lt};
      OP_SLL:  result = a << shamt;
      OP_SRL:  result = a >> shamt;
      // Address generation, rs1 plus immediate
      OP_LW,
      OP_SW:   result = a + b;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/data_ram.sv ====
`default_nettype none

module data_ram #(
  parameter int XLEN      = 32,
  parameter int RAM_WORDS = 16
) (
  input  wire             clk,
  input  wire             arst_n,
  input  fwd_pkg::xlen_t  addr,
  input  wire             we,
  input  wire             re,
  input  fwd_pkg::xlen_t  wdata,
  output fwd_pkg::xlen_t  rdata
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [XLEN-1:0]  mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;

  // Word index, byte offset dropped, upper bits wrap
  assign idx = addr[2 +: IDX_W];

  // Write and registered read share the stage-advance edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else begin
      if (we) begin
        mem[idx] <= wdata;
      end
      if (re) begin
        rdata <= mem[idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hazard_ctrl.sv ====
`default_nettype none

module hazard_ctrl (
  input  wire                in_valid,
  input  wire                out_valid,
  input  wire                out_ready,
  input  wire                id_ex_valid,
  input  wire                id_ex_memread,
  input  fwd_pkg::reg_idx_t  id_ex_rd,
  input  fwd_pkg::reg_idx_t  in_rs1,
  input  fwd_pkg::reg_idx_t  in_rs2,
  input  wire                in_uses_rs2,
  output logic               in_ready,
  output logic               hold,
  output logic               bubble
);

  logic freeze;
  logic load_use;

  // Output back-pressure stops every stage
  assign freeze = out_valid && !out_ready;

  // Offered instruction needs the result of the load in ID/EX
  assign load_use = in_valid && id_ex_valid && id_ex_memread &&
                    (id_ex_rd != '0) &&
                    ((id_ex_rd == in_rs1) ||
                     (in_uses_rs2 && (id_ex_rd == in_rs2)));

  assign hold     = freeze;
  // Empty slot into ID/EX while the load moves on
  assign bubble   = load_use;
  assign in_ready = !freeze && !load_use;

endmodule

`default_nettype wire

// ==== verilog/pipe_stage.sv ====
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  wire       clk,
  input  wire       arst_n,
  input  wire       hold,
  input  wire       flush,
  input  wire       d_valid,
  input  payload_t  d,
  output logic      q_valid,
  output payload_t  q
);

  // Slot occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q_valid <= 1'b0;
    end else if (!hold) begin
      // Flush inserts a bubble
      q_valid <= d_valid && !flush;
    end
  end

  // Payload follows the slot, meaningful only while q_valid is set
  always_ff @(posedge clk) begin
    if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fwd_core.sv ====
`default_nettype none

module fwd_core #(
  parameter int XLEN      = 32,
  parameter int RAM_WORDS = 16
) (
  input  wire                clk,
  input  wire                arst_n,
  // Decoded instruction stream
  input  wire                in_valid,
  output logic               in_ready,
  input  fwd_pkg::op_e       in_op,
  input  fwd_pkg::reg_idx_t  in_rd,
  input  fwd_pkg::reg_idx_t  in_rs1,
  input  fwd_pkg::reg_idx_t  in_rs2,
  input  fwd_pkg::xlen_t     in_imm,
  input  wire                in_alusrc,
  input  wire                in_regwrite,
  // Retire stream
  output logic               out_valid,
  input  wire                out_ready,
  output fwd_pkg::reg_idx_t  out_rd,
  output logic               out_we,
  output fwd_pkg::xlen_t     out_data
);
  import fwd_pkg::*;

  id_ex_t  id_d,  id_q;
  ex_mem_t ex_d,  ex_q;
  mem_wb_t mem_d, mem_q;
  logic    id_valid, ex_valid, mem_valid;

  xlen_t   rs1_val, rs2_val;
  xlen_t   fw_rs1, fw_rs2, rs2_mod, alu_res;
  xlen_t   ram_rdata, wb_data;
  logic    in_is_mem, in_alusrc_eff, in_uses_rs2;
  logic    hold, bubble;

  wb_bus_if wb_i ();

  ////////////////////////////////////////////////////////////////////
  // Issue
  ////////////////////////////////////////////////////////////////////

  // Memory ops always take the immediate as address offset
  assign in_is_mem     = (in_op == OP_LW) || (in_op == OP_SW);
  assign in_alusrc_eff = in_alusrc || in_is_mem;
  // Stores read rs2 for their data
  assign in_uses_rs2   = (in_op == OP_SW) || !in_alusrc_eff;

  regfile #(.XLEN(XLEN)) regfile_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_idx_a  (in_rs1),
    .rd_idx_b  (in_rs2),
    .rd_data_a (rs1_val),
    .rd_data_b (rs2_val),
    .wb        (wb_i.wb_dst)
  );

  // No write for stores or for x0
  assign id_d = '{op: in_op, rd: in_rd, rs1: in_rs1, rs2: in_rs2,
                  rs1_val: rs1_val, rs2_val: rs2_val, imm: in_imm,
                  alusrc: in_alusrc_eff,
                  regwrite: in_regwrite && (in_rd != '0) && (in_op != OP_SW)};

  hazard_ctrl hazard_i (
    .in_valid      (in_valid),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .id_ex_valid   (id_valid),
    .id_ex_memread ((id_q.op == OP_LW) && id_q.regwrite),
    .id_ex_rd      (id_q.rd),
    .in_rs1        (in_rs1),
    .in_rs2        (in_rs2),
    .in_uses_rs2   (in_uses_rs2),
    .in_ready      (in_ready),
    .hold          (hold),
    .bubble        (bubble)
  );

  pipe_stage #(.payload_t(id_ex_t)) id_ex_i (
    .clk (clk), .arst_n (arst_n), .hold (hold), .flush (bubble),
    .d_valid (in_valid), .d (id_d), .q_valid (id_valid), .q (id_q)
  );

  ////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////

  forwarding #(.XLEN(XLEN)) forwarding_i (
    .ex_mem_regwrite (ex_valid && ex_q.regwrite),
    .ex_mem_memread  (ex_q.memread),
    .ex_mem_rd       (ex_q.rd),
    .id_ex_rs1       (id_q.rs1),
    .id_ex_rs2       (id_q.rs2),
    .alures          (ex_q.alures),
    .memres          (wb_data),
    .rs1             (id_q.rs1_val),
    .rs2             (id_q.rs2_val),
    .imm             (id_q.imm),
    .alusrc          (id_q.alusrc),
    .wb              (wb_i.fwd_view),
    .fw_rs1          (fw_rs1),
    .fw_rs2          (fw_rs2),
    .rs2_mod         (rs2_mod)
  );

  exec_alu #(.XLEN(XLEN)) alu_i (
    .op     (id_q.op),
    .a      (fw_rs1),
    .b      (fw_rs2),
    .result (alu_res)
  );

  assign ex_d = '{op: id_q.op, rd: id_q.rd, regwrite: id_q.regwrite,
                  memread: (id_q.op == OP_LW), alures: alu_res,
                  store_data: rs2_mod};

  pipe_stage #(.payload_t(ex_mem_t)) ex_mem_i (
    .clk (clk), .arst_n (arst_n), .hold (hold), .flush (1'b0),
    .d_valid (id_valid), .d (ex_d), .q_valid (ex_valid), .q (ex_q)
  );

  ////////////////////////////////////////////////////////////////////
  // Memory and write-back
  ////////////////////////////////////////////////////////////////////

  // Access happens as the slot moves into MEM/WB
  data_ram #(.XLEN(XLEN), .RAM_WORDS(RAM_WORDS)) ram_i (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (ex_q.alures),
    .we     (ex_valid && (ex_q.op == OP_SW) && !hold),
    .re     (ex_valid && ex_q.memread && !hold),
    .wdata  (ex_q.store_data),
    .rdata  (ram_rdata)
  );

  // Store value kept for the retire record only
  assign mem_d = '{rd: ex_q.rd, regwrite: ex_q.regwrite, memread: ex_q.memread,
                   alures: ex_q.alures,
                   stdata: (ex_q.op == OP_SW) ? ex_q.store_data : '0};

  pipe_stage #(.payload_t(mem_wb_t)) mem_wb_i (
    .clk (clk), .arst_n (arst_n), .hold (hold), .flush (1'b0),
    .d_valid (ex_valid), .d (mem_d), .q_valid (mem_valid), .q (mem_q)
  );

  assign wb_data = mem_q.memread ? ram_rdata : mem_q.alures;

  // Register write only on the output transfer
  assign wb_i.regwrite = out_valid && out_ready && mem_q.regwrite;
  assign wb_i.rd       = mem_q.rd;
  assign wb_i.data     = wb_data;

  // WB/ID echo, covers the write that lands as an instruction issues
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_i.echo <= '0;
    end else if (!hold) begin
      wb_i.echo <= '{regwrite: wb_i.regwrite, rd: wb_i.rd, data: wb_i.data};
    end
  end

  // Retire record
  assign out_valid = mem_valid;
  assign out_rd    = mem_q.rd;
  assign out_we    = mem_q.regwrite;
  assign out_data  = mem_q.regwrite ? wb_data : mem_q.stdata;

endmodule

`default_nettype wire

// ==== dv/fwd_core_assert.sv ====
`default_nettype none

module fwd_core_assert (
  input wire             clk,
  input wire             arst_n,
  input wire             out_valid,
  input wire             out_ready,
  input fwd_pkg::reg_idx_t out_rd,
  input wire             out_we,
  input fwd_pkg::xlen_t  out_data
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  // A stalled record stays offered
  a_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> out_valid)
    else begin
      fail_cnt++;
      $error("out_valid dropped before the record was taken");
    end

  // Its fields do not move until the transfer
  a_fields_held: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> ($stable(out_rd) && $stable(out_we) && $stable(out_data)))
    else begin
      fail_cnt++;
      $error("output record changed while out_ready was low");
    end

  // Nothing retires while in reset
  a_reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      fail_cnt++;
      $error("out_valid high during reset");
    end

endmodule

`default_nettype wire

// ==== dv/fwd_core_tb.sv ====
`default_nettype none

module fwd_core_tb;
  import fwd_pkg::*;

  localparam int XLEN        = 32;
  localparam int RAM_WORDS   = 16;
  localparam int CLK_PERIOD  = 20;
  localparam int N_DIRECTED  = 21;
  localparam int N_RANDOM    = 400;
  localparam int RDY_LEN     = 1024;
  // 20 cycles per instruction plus reset and drain
  localparam int TIMEOUT_CYC = 20 * (N_DIRECTED + N_RANDOM) + 50;

  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;
    logic     alusrc;
    logic     regwrite;
  } instr_t;

  // Expected retire record plus the cycle it was accepted in
  typedef struct packed {
    reg_idx_t    rd;
    logic        we;
    xlen_t       data;
    int unsigned acc_cyc;
  } exp_t;

  logic     clk;
  logic     arst_n;
  logic     in_valid, in_ready, in_alusrc, in_regwrite;
  op_e      in_op;
  reg_idx_t in_rd, in_rs1, in_rs2;
  xlen_t    in_imm;
  logic     out_valid, out_ready, out_we;
  reg_idx_t out_rd;
  xlen_t    out_data;

  // Architectural model
  xlen_t       model_regs [32];
  xlen_t       model_mem [RAM_WORDS];
  exp_t        exp_q [$];
  bit          rdy_pat [RDY_LEN];
  integer      seed = 73889;
  int unsigned cyc;
  bit          bp_on;
  bit          lat_check;
  // rd of a load sitting in ID/EX or zero when there is none
  reg_idx_t    idex_load_rd;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fwd_core #(.XLEN(XLEN), .RAM_WORDS(RAM_WORDS)) dut_i (
    .clk (clk), .arst_n (arst_n),
    .in_valid (in_valid), .in_ready (in_ready), .in_op (in_op), .in_rd (in_rd),
    .in_rs1 (in_rs1), .in_rs2 (in_rs2), .in_imm (in_imm),
    .in_alusrc (in_alusrc), .in_regwrite (in_regwrite),
    .out_valid (out_valid), .out_ready (out_ready), .out_rd (out_rd),
    .out_we (out_we), .out_data (out_data)
  );

  bind fwd_core fwd_core_assert assert_i (
    .clk (clk), .arst_n (arst_n), .out_valid (out_valid), .out_ready (out_ready),
    .out_rd (out_rd), .out_we (out_we), .out_data (out_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: time %0t signal %s got 0x%08h expected 0x%08h",
               $time, name, got, exp);
      stop_run();
    end
  endtask

  function automatic instr_t make_instr(input op_e op, input reg_idx_t rd,
                                        input reg_idx_t rs1, input reg_idx_t rs2,
                                        input xlen_t imm, input logic alusrc,
                                        input logic regwrite);
    instr_t ins;
    ins = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, alusrc: alusrc,
            regwrite: regwrite};
    return ins;
  endfunction

  // Executes one instruction on the model in program order
  function automatic exp_t ref_exec(input instr_t ins);
    exp_t  e;
    xlen_t a;
    xlen_t b;
    xlen_t res;
    xlen_t addr;
    logic  imm_sel;
    logic  wr;
    int    widx;
    a       = model_regs[ins.rs1];
    // Loads and stores always add the immediate
    imm_sel = ins.alusrc || (ins.op == OP_LW) || (ins.op == OP_SW);
    b       = imm_sel ? ins.imm : model_regs[ins.rs2];
    addr    = a + ins.imm;
    widx    = int'((addr >> 2) % RAM_WORDS);
    wr      = ins.regwrite && (ins.rd != 0) && (ins.op != OP_SW);
    case (ins.op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLL:  res = a << b[4:0];
      OP_SRL:  res = a >> b[4:0];
      OP_LW:   res = model_mem[widx];
      default: res = model_regs[ins.rs2];
    endcase
    if (ins.op == OP_SW) begin
      model_mem[widx] = res;
    end
    if (wr) begin
      model_regs[ins.rd] = res;
    end
    e.rd      = ins.rd;
    e.we      = wr;
    // Store reports its data and other non-writes report zero
    e.data    = (wr || (ins.op == OP_SW)) ? res : '0;
    e.acc_cyc = 0;
    return e;
  endfunction

  // Registers 0..7 only so that hazards are frequent
  function automatic instr_t rand_instr();
    instr_t ins;
    ins.op       = op_e'($unsigned($random(seed)) % 10);
    ins.rd       = reg_idx_t'($unsigned($random(seed)) % 8);
    ins.rs1      = reg_idx_t'($unsigned($random(seed)) % 8);
    ins.rs2      = reg_idx_t'($unsigned($random(seed)) % 8);
    // Small word offsets keep memory traffic on shared addresses
    ins.imm      = (ins.op inside {OP_LW, OP_SW}) ? xlen_t'(($random(seed) % 16) * 4)
                                                  : xlen_t'($random(seed));
    ins.alusrc   = ($random(seed) & 1) != 0;
    ins.regwrite = ($unsigned($random(seed)) % 8) != 0;
    return ins;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Offer one instruction and return at its transfer edge
  task automatic send_instr(input instr_t ins);
    in_valid    <= 1'b1;
    in_op       <= ins.op;
    in_rd       <= ins.rd;
    in_rs1      <= ins.rs1;
    in_rs2      <= ins.rs2;
    in_imm      <= ins.imm;
    in_alusrc   <= ins.alusrc;
    in_regwrite <= ins.regwrite;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
  endtask

  // Queue is looked at between edges and the task returns on a rising edge
  task automatic wait_drain();
    in_valid <= 1'b0;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  always @(posedge clk) begin
    cyc       <= cyc + 1;
    out_ready <= bp_on ? rdy_pat[cyc % RDY_LEN] : 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////////////

  // Accepted instructions go through the model
  always @(posedge clk) begin
    exp_t e;
    if (arst_n && in_valid && in_ready) begin
      e = ref_exec(make_instr(in_op, in_rd, in_rs1, in_rs2, in_imm, in_alusrc,
                              in_regwrite));
      e.acc_cyc = cyc;
      exp_q.push_back(e);
    end
  end

  // Retired records against the model in order
  always @(posedge clk) begin
    exp_t e;
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: time %0t a record retired with no instruction in flight", $time);
        stop_run();
      end else begin
        e = exp_q.pop_front();
        check_value("out_rd", 32'(out_rd), 32'(e.rd));
        check_value("out_we", 32'(out_we), 32'(e.we));
        check_value("out_data", out_data, e.data);
        if (lat_check) begin
          check_value("latency", cyc - e.acc_cyc, 32'd3);
        end
      end
    end
  end

  // in_ready follows back-pressure and the one-cycle load-use stall
  always @(posedge clk) begin
    logic freeze;
    logic stall;
    logic uses_rs2;
    if (arst_n) begin
      freeze   = out_valid && !out_ready;
      uses_rs2 = (in_op == OP_SW) || !(in_alusrc || (in_op == OP_LW));
      stall    = in_valid && !freeze && (idex_load_rd != 0) &&
                 ((in_rs1 == idex_load_rd) || (uses_rs2 && (in_rs2 == idex_load_rd)));
      check_value("in_ready", 32'(in_ready), 32'(!freeze && !stall));
      if (!freeze) begin
        idex_load_rd = (in_valid && in_ready && (in_op == OP_LW) && in_regwrite) ?
                       in_rd : '0;
      end
    end
  end

  // Any failed handshake assertion ends the run
  always @(posedge clk) begin
    if (dut_i.assert_i.fail_cnt != 0) begin
      $display("ERROR: time %0t a handshake assertion on the retire port failed", $time);
      stop_run();
    end
  end

  initial begin
    #(CLK_PERIOD * TIMEOUT_CYC);
    $display("ERROR: time %0t timeout, the pipeline stopped making progress", $time);
    stop_run();
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_op        = OP_ADD;
    in_rd        = '0;
    in_rs1       = '0;
    in_rs2       = '0;
    in_imm       = '0;
    in_alusrc    = 1'b0;
    in_regwrite  = 1'b0;
    out_ready    = 1'b1;
    bp_on        = 1'b0;
    lat_check    = 1'b0;
    cyc          = 0;
    idex_load_rd = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    // Roughly one cycle in four with out_ready low
    for (int i = 0; i < RDY_LEN; i++) begin
      rdy_pat[i] = ($unsigned($random(seed)) % 4) != 0;
    end
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // Dependent chain where distances 1 to 3 hit EX/MEM, MEM/WB and echo
    send_instr(make_instr(OP_ADD, 1, 0, 0, 5, 1, 1));
    send_instr(make_instr(OP_ADD, 2, 1, 0, 3, 1, 1));
    send_instr(make_instr(OP_ADD, 3, 1, 2, 0, 0, 1));
    send_instr(make_instr(OP_SUB, 4, 3, 1, 0, 0, 1));
    send_instr(make_instr(OP_XOR, 5, 4, 2, 0, 0, 1));
    send_instr(make_instr(OP_SLT, 6, 5, 4, 0, 0, 1));
    send_instr(make_instr(OP_SLL, 7, 1, 0, 4, 1, 1));
    send_instr(make_instr(OP_SRL, 6, 7, 1, 0, 0, 1));
    send_instr(make_instr(OP_AND, 1, 6, 7, 0, 0, 1));
    send_instr(make_instr(OP_OR, 2, 1, 3, 0, 0, 1));
    // x0 as destination and read right behind it
    send_instr(make_instr(OP_ADD, 0, 1, 0, 77, 1, 1));
    send_instr(make_instr(OP_ADD, 3, 0, 0, 0, 0, 1));
    // Store and load with uses right after the loads
    send_instr(make_instr(OP_ADD, 4, 0, 0, 32'h1234, 1, 1));
    send_instr(make_instr(OP_SW, 0, 0, 4, 8, 1, 0));
    send_instr(make_instr(OP_LW, 5, 0, 0, 8, 1, 1));
    send_instr(make_instr(OP_ADD, 6, 5, 5, 0, 0, 1));
    send_instr(make_instr(OP_LW, 7, 0, 0, 8, 1, 1));
    send_instr(make_instr(OP_SW, 0, 0, 7, 12, 1, 0));
    send_instr(make_instr(OP_LW, 1, 0, 0, 12, 0, 1));
    send_instr(make_instr(OP_OR, 2, 1, 0, 32'hf0, 1, 1));
    wait_drain();

    // Lone instruction into an empty pipeline
    lat_check <= 1'b1;
    send_instr(make_instr(OP_ADD, 3, 2, 0, 1, 1, 1));
    wait_drain();
    lat_check <= 1'b0;

    // Long random program with output gaps and input idles
    bp_on <= 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      send_instr(rand_instr());
      if (($unsigned($random(seed)) % 8) == 0) begin
        in_valid <= 1'b0;
        @(posedge clk);
      end
    end
    wait_drain();

    if (dut_i.assert_i.fail_cnt != 0) begin
      $display("ERROR: a handshake assertion on the retire port failed");
      stop_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== fwd_core.f ====
verilog/fwd_pkg.sv
verilog/wb_bus_if.sv
verilog/regfile.sv
verilog/forwarding.sv
verilog/exec_alu.sv
verilog/data_ram.sv
verilog/hazard_ctrl.sv
verilog/pipe_stage.sv
verilog/fwd_core.sv
dv/fwd_core_assert.sv
dv/fwd_core_tb.sv
